// File: rtl/exc_pkg.sv
package exc_pkg;

  //////////////////////////////////////////////////////////////////////
  // line count limits
  //////////////////////////////////////////////////////////////////////

  // width of the line number in the cause word
  localparam int IRQ_ID_W = 5;

  // upper bound on the number of interrupt lines
  localparam int MAX_IRQ = 2 ** IRQ_ID_W;

  //////////////////////////////////////////////////////////////////////
  // exception codes
  //////////////////////////////////////////////////////////////////////

  // synchronous exceptions, top bit always zero
  localparam logic [5:0] CAUSE_ILLEGAL   = 6'd2;
  localparam logic [5:0] CAUSE_LOAD_ERR  = 6'd5;
  localparam logic [5:0] CAUSE_STORE_ERR = 6'd7;
  localparam logic [5:0] CAUSE_ECALL     = 6'd8;

  //////////////////////////////////////////////////////////////////////
  // handler address select
  //////////////////////////////////////////////////////////////////////

  // load and store errors share one handler
  typedef enum logic [1:0] {
    PC_SEL_IRQ     = 2'd0,
    PC_SEL_ECALL   = 2'd1,
    PC_SEL_ILLINSN = 2'd2,
    PC_SEL_LSU     = 2'd3
  } pc_sel_e;

  //////////////////////////////////////////////////////////////////////
  // cause word
  //////////////////////////////////////////////////////////////////////

  // interrupt view
  // flag is one, id is the winning line
  typedef struct packed {
    logic                is_irq;
    logic [IRQ_ID_W-1:0] id;
  } irq_cause_t;

  // same six bits, read as interrupt or as exception code
  typedef union packed {
    irq_cause_t  intr;
    logic [5:0]  code;
  } cause_t;

endpackage

// File: rtl/irq_line.sv
module irq_line (
  input  logic clk,
  input  logic rst_n,

  // raw level from outside, no timing relation to clk
  input  logic irq_i,

  // enable bit for this line from the register block
  input  logic mask_i,

  // synchronized and masked request
  output logic pend_o
);

  //////////////////////////////////////////////////////////////////////
  // two-stage synchronizer
  //////////////////////////////////////////////////////////////////////

  // first stage may go metastable
  logic meta_q;

  // second stage is safe to use
  logic sync_q;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      meta_q <= 1'b0;
      sync_q <= 1'b0;
    end
    else
    begin
      meta_q <= irq_i;
      sync_q <= meta_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // mask gating
  //////////////////////////////////////////////////////////////////////

  // combinational after the second flop
  // so a mask write acts one edge after the strobe
  assign pend_o = sync_q & mask_i;

endmodule

// File: rtl/irq_csr.sv
module irq_csr #(
  parameter int NUM_IRQ = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // mask write port
  input  logic                 wr_mask_i,
  input  logic [NUM_IRQ-1:0]   wr_data_i,

  // global enable write port
  input  logic                 wr_enable_i,
  input  logic                 enable_data_i,

  // cause capture from the exception controller
  input  logic                 save_cause_i,
  input  exc_pkg::cause_t      cause_i,

  // to the line cells and the controller
  output logic [NUM_IRQ-1:0]   mask_o,
  output logic                 irq_enable_o,

  // read-only cause register
  output exc_pkg::cause_t      mcause_o
);

  //////////////////////////////////////////////////////////////////////
  // register state
  //////////////////////////////////////////////////////////////////////

  logic [NUM_IRQ-1:0] mask_q;
  logic               enable_q;
  exc_pkg::cause_t    mcause_q;

  // per-line mask, one bit per line
  // all lines disabled out of reset
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      mask_q <= '0;
    else if (wr_mask_i)
      mask_q <= wr_data_i;
  end

  // global interrupt enable
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      enable_q <= 1'b0;
    else if (wr_enable_i)
      enable_q <= enable_data_i;
  end

  // saved trap cause
  // kept until the next trap is taken
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      mcause_q <= '0;
    else if (save_cause_i)
      mcause_q <= cause_i;
  end

  assign mask_o       = mask_q;
  assign irq_enable_o = enable_q;
  assign mcause_o     = mcause_q;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // cause register moves only one edge after a save pulse
  a_mcause_only_on_save: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$stable(mcause_o) |-> $past(save_cause_i)
  ) else $error("mcause changed without a save pulse");

endmodule

// File: rtl/exc_controller.sv
module exc_controller #(
  parameter int NUM_IRQ = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,

  // synchronized, masked lines and global enable
  input  logic [NUM_IRQ-1:0]            pend_i,
  input  logic                          irq_enable_i,

  // decoder flags
  input  logic                          illegal_insn_i,
  input  logic                          ecall_insn_i,
  input  logic                          eret_insn_i,

  // lsu flags
  input  logic                          load_err_i,
  input  logic                          store_err_i,

  // req/ack pair with the core controller
  output logic                          req_o,
  input  logic                          ack_i,

  // handler address select
  output exc_pkg::pc_sel_e              pc_sel_o,
  output logic [exc_pkg::IRQ_ID_W-1:0]  vec_sel_o,

  // to the register block
  output exc_pkg::cause_t               cause_o,
  output logic                          save_cause_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_HANDLER
  } state_e;

  state_e state_q;
  state_e state_d;

  logic              irq_any;
  logic              req_int;
  logic              bypass;
  exc_pkg::cause_t   cause_int;
  exc_pkg::cause_t   cause_q;
  exc_pkg::pc_sel_e  pc_sel_int;
  exc_pkg::pc_sel_e  pc_sel_q;

  //////////////////////////////////////////////////////////////////////
  // source merge and priority
  //////////////////////////////////////////////////////////////////////

  // interrupts only count with global enable set
  assign irq_any = irq_enable_i & (|pend_i);

  assign req_int = irq_any
                 | ecall_insn_i
                 | illegal_insn_i
                 | load_err_i
                 | store_err_i;

  // later assignments win
  // so the list runs from lowest to highest priority
  always_comb
  begin
    cause_int  = '0;
    pc_sel_int = exc_pkg::PC_SEL_IRQ;

    // scan down, lowest active line ends up on top
    for (int i = NUM_IRQ - 1; i >= 0; i--)
    begin
      if (irq_enable_i && pend_i[i])
      begin
        cause_int.intr.is_irq = 1'b1;
        cause_int.intr.id     = exc_pkg::IRQ_ID_W'(i);
      end
    end

    if (ecall_insn_i)
    begin
      cause_int.code = exc_pkg::CAUSE_ECALL;
      pc_sel_int     = exc_pkg::PC_SEL_ECALL;
    end

    if (illegal_insn_i)
    begin
      cause_int.code = exc_pkg::CAUSE_ILLEGAL;
      pc_sel_int     = exc_pkg::PC_SEL_ILLINSN;
    end

    if (load_err_i)
    begin
      cause_int.code = exc_pkg::CAUSE_LOAD_ERR;
      pc_sel_int     = exc_pkg::PC_SEL_LSU;
    end

    // store error beats everything
    if (store_err_i)
    begin
      cause_int.code = exc_pkg::CAUSE_STORE_ERR;
      pc_sel_int     = exc_pkg::PC_SEL_LSU;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // cause hold and bypass
  //////////////////////////////////////////////////////////////////////

  // first cycle of a new request
  assign bypass = (state_q == ST_IDLE) && req_int;

  // capture on the edge that leaves idle
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      cause_q  <= '0;
      pc_sel_q <= exc_pkg::PC_SEL_IRQ;
    end
    else if (bypass)
    begin
      cause_q  <= cause_int;
      pc_sel_q <= pc_sel_int;
    end
  end

  assign cause_o  = bypass ? cause_int  : cause_q;
  assign pc_sel_o = bypass ? pc_sel_int : pc_sel_q;

  // vector only for interrupts
  assign vec_sel_o = cause_o.intr.is_irq ? cause_o.intr.id : '0;

  //////////////////////////////////////////////////////////////////////
  // request FSM
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d      = state_q;
    req_o        = 1'b0;
    save_cause_o = 1'b0;

    unique case (state_q)
      ST_IDLE:
      begin
        req_o = req_int;
        if (req_int)
          state_d = ST_WAIT;
      end

      // hold req until the core takes it
      ST_WAIT:
      begin
        req_o = 1'b1;
        if (ack_i)
        begin
          save_cause_o = 1'b1;
          state_d      = ST_HANDLER;
        end
      end

      // no new requests until eret
      ST_HANDLER:
      begin
        if (eret_insn_i)
          state_d = ST_IDLE;
      end

      default:
      begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // an unanswered request never drops
  a_req_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    (req_o && !ack_i) |=> req_o
  ) else $error("req dropped without ack");

  // save pulse only from wait, and it leads into the handler
  a_save_in_wait: assert property (
    @(posedge clk) disable iff (!rst_n)
    save_cause_o |-> (state_q == ST_WAIT) ##1 (state_q == ST_HANDLER)
  ) else $error("save_cause outside wait state");

  // cause and pc select frozen while waiting for ack
  a_cause_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q == ST_WAIT) |-> ($stable(cause_o) && $stable(pc_sel_o))
  ) else $error("cause changed while waiting for ack");

endmodule

// File: rtl/exc_unit_top.sv
module exc_unit_top #(
  parameter int NUM_IRQ = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,

  // asynchronous interrupt levels
  input  logic [NUM_IRQ-1:0]            irq_i,

  // decoder flags
  input  logic                          illegal_insn_i,
  input  logic                          ecall_insn_i,
  input  logic                          eret_insn_i,

  // lsu flags
  input  logic                          load_err_i,
  input  logic                          store_err_i,

  // register write strobes, stand-in for csr instructions
  input  logic                          wr_mask_i,
  input  logic [NUM_IRQ-1:0]            wr_data_i,
  input  logic                          wr_enable_i,
  input  logic                          enable_data_i,

  // core controller side
  input  logic                          ack_i,
  output logic                          req_o,
  output exc_pkg::pc_sel_e              pc_sel_o,
  output logic [exc_pkg::IRQ_ID_W-1:0]  vec_sel_o,
  output exc_pkg::cause_t               cause_o,
  output logic                          save_cause_o,

  // register read side
  output exc_pkg::cause_t               mcause_o,
  output logic                          irq_enable_o
);

  logic [NUM_IRQ-1:0] mask;
  logic [NUM_IRQ-1:0] pend;

  // line number must fit the cause word
  if ((NUM_IRQ < 1) || (NUM_IRQ > exc_pkg::MAX_IRQ))
  begin : g_num_irq_check
    $error("NUM_IRQ out of range");
  end

  //////////////////////////////////////////////////////////////////////
  // mask, enable and cause registers
  //////////////////////////////////////////////////////////////////////

  irq_csr #(
    .NUM_IRQ       (NUM_IRQ)
  ) u_irq_csr (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_mask_i     (wr_mask_i),
    .wr_data_i     (wr_data_i),
    .wr_enable_i   (wr_enable_i),
    .enable_data_i (enable_data_i),
    .save_cause_i  (save_cause_o),
    .cause_i       (cause_o),
    .mask_o        (mask),
    .irq_enable_o  (irq_enable_o),
    .mcause_o      (mcause_o)
  );

  //////////////////////////////////////////////////////////////////////
  // one cell per line
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < NUM_IRQ; k++)
  begin : g_line
    irq_line u_irq_line (
      .clk    (clk),
      .rst_n  (rst_n),
      .irq_i  (irq_i[k]),
      .mask_i (mask[k]),
      .pend_o (pend[k])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // priority and handshake
  //////////////////////////////////////////////////////////////////////

  exc_controller #(
    .NUM_IRQ        (NUM_IRQ)
  ) u_exc_controller (
    .clk            (clk),
    .rst_n          (rst_n),
    .pend_i         (pend),
    .irq_enable_i   (irq_enable_o),
    .illegal_insn_i (illegal_insn_i),
    .ecall_insn_i   (ecall_insn_i),
    .eret_insn_i    (eret_insn_i),
    .load_err_i     (load_err_i),
    .store_err_i    (store_err_i),
    .req_o          (req_o),
    .ack_i          (ack_i),
    .pc_sel_o       (pc_sel_o),
    .vec_sel_o      (vec_sel_o),
    .cause_o        (cause_o),
    .save_cause_o   (save_cause_o)
  );

endmodule

// File: test/tb_exc_unit.sv
module tb_exc_unit;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_IRQ         = 8;
  localparam int MAX_CASES       = 64;
  localparam int CYCLES_PER_CASE = 20;

  logic                clk;
  logic                rst_n;
  logic [NUM_IRQ-1:0]  irq_i;
  logic                illegal_insn_i;
  logic                ecall_insn_i;
  logic                eret_insn_i;
  logic                load_err_i;
  logic                store_err_i;
  logic                wr_mask_i;
  logic [NUM_IRQ-1:0]  wr_data_i;
  logic                wr_enable_i;
  logic                enable_data_i;
  logic                ack_i;
  logic                req_o;
  exc_pkg::pc_sel_e    pc_sel_o;
  logic [4:0]          vec_sel_o;
  exc_pkg::cause_t     cause_o;
  logic                save_cause_o;
  exc_pkg::cause_t     mcause_o;
  logic                irq_enable_o;

  // one entry per line of the case file
  logic [7:0] case_mask  [MAX_CASES];
  logic       case_en    [MAX_CASES];
  logic [7:0] case_irq   [MAX_CASES];
  logic       case_ill   [MAX_CASES];
  logic       case_ecall [MAX_CASES];
  logic       case_ld    [MAX_CASES];
  logic       case_st    [MAX_CASES];
  logic       case_req   [MAX_CASES];
  logic [5:0] case_cause [MAX_CASES];
  logic [1:0] case_pc    [MAX_CASES];

  int n_cases     = 0;
  int case_errs   = 0;
  int bad_cases   = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  exc_unit_top #(
    .NUM_IRQ (NUM_IRQ)
  ) UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_i          (irq_i),
    .illegal_insn_i (illegal_insn_i),
    .ecall_insn_i   (ecall_insn_i),
    .eret_insn_i    (eret_insn_i),
    .load_err_i     (load_err_i),
    .store_err_i    (store_err_i),
    .wr_mask_i      (wr_mask_i),
    .wr_data_i      (wr_data_i),
    .wr_enable_i    (wr_enable_i),
    .enable_data_i  (enable_data_i),
    .ack_i          (ack_i),
    .req_o          (req_o),
    .pc_sel_o       (pc_sel_o),
    .vec_sel_o      (vec_sel_o),
    .cause_o        (cause_o),
    .save_cause_o   (save_cause_o),
    .mcause_o       (mcause_o),
    .irq_enable_o   (irq_enable_o)
  );

  //////////////////////////////////////////////////////////////////////
  // clock and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // limit known only once the case file is in
  initial
  begin
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // drive point, 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act)
    begin
      $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      case_errs++;
    end
  endtask

  task automatic load_cases();
    int    fd;
    int    rc;
    string line;
    logic [7:0] t_mask;
    logic       t_en;
    logic [7:0] t_irq;
    logic       t_ill;
    logic       t_ecall;
    logic       t_ld;
    logic       t_st;
    logic       t_req;
    logic [5:0] t_cause;
    logic [1:0] t_pc;
    fd = $fopen("test/exc_cases.mem", "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        rc = $fgets(line, fd);
        // comment and blank lines do not scan to ten fields
        if (rc > 0)
          rc = $sscanf(line, "%h %b %h %b %b %b %b %b %h %h", t_mask, t_en, t_irq,
                       t_ill, t_ecall, t_ld, t_st, t_req, t_cause, t_pc);
        if (rc == 10 && n_cases < MAX_CASES)
        begin
          case_mask[n_cases]  = t_mask;
          case_en[n_cases]    = t_en;
          case_irq[n_cases]   = t_irq;
          case_ill[n_cases]   = t_ill;
          case_ecall[n_cases] = t_ecall;
          case_ld[n_cases]    = t_ld;
          case_st[n_cases]    = t_st;
          case_req[n_cases]   = t_req;
          case_cause[n_cases] = t_cause;
          case_pc[n_cases]    = t_pc;
          n_cases++;
        end
      end
      $fclose(fd);
    end
  endtask

  // mask and enable strobes, register updates on this edge
  task automatic write_regs(input logic [7:0] mask, input logic en);
    wr_mask_i     = 1'b1;
    wr_data_i     = mask;
    wr_enable_i   = 1'b1;
    enable_data_i = en;
    step();
    wr_mask_i   = 1'b0;
    wr_enable_i = 1'b0;
  endtask

  task automatic apply_sources(input logic [7:0] irq, input logic ill, input logic ecall,
                               input logic ld, input logic st);
    irq_i          = irq;
    illegal_insn_i = ill;
    ecall_insn_i   = ecall;
    load_err_i     = ld;
    store_err_i    = st;
  endtask

  //////////////////////////////////////////////////////////////////////
  // one case, acting as core controller
  //////////////////////////////////////////////////////////////////////

  task automatic run_case(input int i);
    int          wait_cyc;
    int          delay;
    logic        got;
    logic        any_exc;
    logic [31:0] exp_vec;
    any_exc  = case_ill[i] | case_ecall[i] | case_ld[i] | case_st[i];
    // vector is the line number for interrupts only
    exp_vec  = case_cause[i][5] ? 32'(case_cause[i][4:0]) : 32'd0;
    wait_cyc = 0;
    write_regs(case_mask[i], case_en[i]);
    check_value("irq_enable_o", 32'(case_en[i]), 32'(irq_enable_o));
    apply_sources(case_irq[i], case_ill[i], case_ecall[i], case_ld[i], case_st[i]);
    #2;
    got = req_o;
    while (!got && wait_cyc < 4)
    begin
      step();
      #2;
      wait_cyc++;
      got = req_o;
    end

    if (!case_req[i])
    begin
      if (got)
      begin
        $display("case %0d: req_o rose although every source is masked or disabled", i);
        case_errs++;
      end
    end
    else if (!got)
    begin
      $display("case %0d: req_o never rose within 4 cycles", i);
      case_errs++;
    end
    else
    begin
      // exceptions same cycle, interrupts after the synchronizer
      check_value("req_o latency", any_exc ? 32'd0 : 32'd2, 32'(wait_cyc));
      check_value("cause_o", 32'(case_cause[i]), 32'(cause_o));
      check_value("pc_sel_o", 32'(case_pc[i]), 32'(pc_sel_o));
      check_value("vec_sel_o", exp_vec, 32'(vec_sel_o));

      // back-pressure with the highest priority source switched on
      delay = int'($urandom % 6);
      step();
      apply_sources(8'hff, 1'b0, 1'b0, 1'b0, 1'b1);
      #2;
      check_value("req_o", 32'd1, 32'(req_o));
      check_value("cause_o", 32'(case_cause[i]), 32'(cause_o));
      repeat (delay)
      begin
        step();
        #2;
        check_value("req_o", 32'd1, 32'(req_o));
        check_value("cause_o", 32'(case_cause[i]), 32'(cause_o));
      end

      step();
      ack_i = 1'b1;
      #2;
      check_value("save_cause_o", 32'd1, 32'(save_cause_o));
      check_value("cause_o", 32'(case_cause[i]), 32'(cause_o));
      step();
      ack_i = 1'b0;
      #2;
      check_value("mcause_o", 32'(case_cause[i]), 32'(mcause_o));
      check_value("save_cause_o", 32'd0, 32'(save_cause_o));
      check_value("req_o", 32'd0, 32'(req_o));

      // in handler, sources still up, no eret yet
      step();
      #2;
      check_value("req_o", 32'd0, 32'(req_o));
    end

    // drop sources and let the synchronizers drain
    step();
    apply_sources(8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (3)
    begin
      #2;
      check_value("req_o", 32'd0, 32'(req_o));
      step();
    end
    eret_insn_i = 1'b1;
    step();
    eret_insn_i = 1'b0;
    #2;
    check_value("req_o", 32'd0, 32'(req_o));
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(10));
    rst_n          = 1'b0;
    irq_i          = '0;
    illegal_insn_i = 1'b0;
    ecall_insn_i   = 1'b0;
    eret_insn_i    = 1'b0;
    load_err_i     = 1'b0;
    store_err_i    = 1'b0;
    wr_mask_i      = 1'b0;
    wr_data_i      = '0;
    wr_enable_i    = 1'b0;
    enable_data_i  = 1'b0;
    ack_i          = 1'b0;

    load_cases();
    cycle_limit = n_cases * CYCLES_PER_CASE + 100;

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    if (n_cases == 0)
    begin
      $display("no cases could be read from test/exc_cases.mem");
      bad_cases++;
    end

    for (int i = 0; i < n_cases; i++)
    begin
      case_errs = 0;
      run_case(i);
      if (case_errs == 0)
        $display("case %0d: ok", i);
      else
      begin
        $display("case %0d: %0d errors", i, case_errs);
        bad_cases++;
      end
    end

    $display("%0d cases run, %0d ok, %0d with errors", n_cases, n_cases - bad_cases, bad_cases);
    if (bad_cases == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: test/exc_cases.mem
// mask en irq illegal ecall load store req cause pc_sel
// mask, irq, cause, pc_sel in hex, the other columns single bits
00 0 00 1 0 0 0 1 02 2
00 0 00 0 1 0 0 1 08 1
00 0 00 0 0 1 0 1 05 3
00 0 00 0 0 0 1 1 07 3
00 0 00 1 1 0 0 1 02 2
00 0 00 0 1 1 0 1 05 3
00 0 00 1 1 1 1 1 07 3
ff 1 08 0 0 0 0 1 23 0
ff 1 a4 0 0 0 0 1 22 0
f0 1 a4 0 0 0 0 1 25 0
0f 1 f0 0 0 0 0 0 00 0
ff 0 ff 0 0 0 0 0 00 0
ff 1 01 0 1 0 0 1 08 1
80 1 80 0 0 0 0 1 27 0
01 1 01 0 0 0 0 1 20 0

// File: vlog.f
rtl/exc_pkg.sv
rtl/irq_line.sv
rtl/irq_csr.sv
rtl/exc_controller.sv
rtl/exc_unit_top.sv
test/tb_exc_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f vlog.f --top-module tb_exc_unit -o tb_exc_unit_sim

./obj_dir/tb_exc_unit_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
exit 0
